// File: ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define EX_XLEN       32
`define EX_REG_AW     5

// rv32i major opcodes
`define EX_OPC_OP_IMM 7'b0010011
`define EX_OPC_OP     7'b0110011
`define EX_OPC_BRANCH 7'b1100011
`define EX_OPC_JAL    7'b1101111
`define EX_OPC_JALR   7'b1100111
`define EX_OPC_LUI    7'b0110111
`define EX_OPC_AUIPC  7'b0010111

// alu group funct3
`define EX_F3_ADD_SUB 3'b000
`define EX_F3_SLL     3'b001
`define EX_F3_SLT     3'b010
`define EX_F3_SLTU    3'b011
`define EX_F3_XOR     3'b100
`define EX_F3_SR      3'b101
`define EX_F3_OR      3'b110
`define EX_F3_AND     3'b111

// branch group funct3
`define EX_F3_BEQ     3'b000
`define EX_F3_BNE     3'b001
`define EX_F3_BLT     3'b100
`define EX_F3_BGE     3'b101
`define EX_F3_BLTU    3'b110
`define EX_F3_BGEU    3'b111
`define EX_F3_JALR    3'b000

`define EX_F7_ALT_BIT 30  // sub / sra select

`endif

// File: ex_pkg.sv
`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]   word_t;
    typedef logic [`EX_REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } branch_op_e;

endpackage

// File: ex_op_if.sv
interface ex_op_if;

    logic                  valid;
    ex_pkg::alu_op_e       alu_op;
    ex_pkg::branch_op_e    branch_op;
    ex_pkg::word_t         op_a;
    ex_pkg::word_t         op_b;
    ex_pkg::word_t         imm;  // i, b or j form by branch_op
    ex_pkg::word_t         pc;
    ex_pkg::reg_addr_t     rd;
    logic                  wr_en;

    modport producer (
        output valid, alu_op, branch_op, op_a, op_b, imm, pc, rd, wr_en
    );

    modport alu (
        input alu_op, op_a, op_b
    );

    modport branch (
        input branch_op, op_a, op_b, imm, pc
    );

    modport commit (
        input valid, wr_en, rd, branch_op, pc
    );

endinterface

// File: ex_decode.sv
`include "ex_defs.svh"

module ex_decode (
    input  ex_pkg::word_t inst_i,
    input  logic          inst_valid_i,
    input  ex_pkg::word_t inst_addr_i,
    input  ex_pkg::word_t reg1_rdata_i,
    input  ex_pkg::word_t reg2_rdata_i,
    ex_op_if.producer     op
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          alt;
    logic          f7_rest_zero;
    ex_pkg::word_t imm_i;
    ex_pkg::word_t imm_b;
    ex_pkg::word_t imm_j;
    ex_pkg::word_t imm_u;

    function automatic ex_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt_i);
        case (f3)
            `EX_F3_ADD_SUB: f3_to_alu = alt_i ? ex_pkg::ALU_SUB : ex_pkg::ALU_ADD;
            `EX_F3_SLL:     f3_to_alu = ex_pkg::ALU_SLL;
            `EX_F3_SLT:     f3_to_alu = ex_pkg::ALU_SLT;
            `EX_F3_SLTU:    f3_to_alu = ex_pkg::ALU_SLTU;
            `EX_F3_XOR:     f3_to_alu = ex_pkg::ALU_XOR;
            `EX_F3_SR:      f3_to_alu = alt_i ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
            `EX_F3_OR:      f3_to_alu = ex_pkg::ALU_OR;
            default:        f3_to_alu = ex_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode       = inst_i[6:0];
    assign funct3       = inst_i[14:12];
    assign funct7       = inst_i[31:25];
    assign alt          = inst_i[`EX_F7_ALT_BIT];
    assign f7_rest_zero = ({funct7[6], funct7[4:0]} == 6'b0);  // all but the alt bit

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    assign op.valid = inst_valid_i;
    assign op.pc    = inst_addr_i;
    assign op.rd    = inst_i[11:7];

    always_comb begin
        op.alu_op    = ex_pkg::ALU_ADD;
        op.branch_op = ex_pkg::BR_NONE;
        op.op_a      = reg1_rdata_i;
        op.op_b      = reg2_rdata_i;
        op.imm       = imm_i;
        op.wr_en     = 1'b0;  // unsupported encodings stay quiet
        case (opcode)
            `EX_OPC_OP_IMM: begin
                op.op_b   = imm_i;
                op.alu_op = f3_to_alu(funct3, alt && (funct3 == `EX_F3_SR));
                case (funct3)
                    `EX_F3_SLL: op.wr_en = f7_rest_zero && !alt;
                    `EX_F3_SR:  op.wr_en = f7_rest_zero;
                    default:    op.wr_en = 1'b1;
                endcase
            end
            `EX_OPC_OP: begin
                op.alu_op = f3_to_alu(funct3, alt);
                op.wr_en  = f7_rest_zero &&
                            (!alt || funct3 == `EX_F3_ADD_SUB || funct3 == `EX_F3_SR);
            end
            `EX_OPC_BRANCH: begin
                op.imm = imm_b;
                case (funct3)
                    `EX_F3_BEQ:  op.branch_op = ex_pkg::BR_BEQ;
                    `EX_F3_BNE:  op.branch_op = ex_pkg::BR_BNE;
                    `EX_F3_BLT:  op.branch_op = ex_pkg::BR_BLT;
                    `EX_F3_BGE:  op.branch_op = ex_pkg::BR_BGE;
                    `EX_F3_BLTU: op.branch_op = ex_pkg::BR_BLTU;
                    `EX_F3_BGEU: op.branch_op = ex_pkg::BR_BGEU;
                    default:     op.branch_op = ex_pkg::BR_NONE;
                endcase
            end
            `EX_OPC_JAL: begin
                op.imm       = imm_j;
                op.branch_op = ex_pkg::BR_JAL;
                op.wr_en     = 1'b1;
            end
            `EX_OPC_JALR: begin
                if (funct3 == `EX_F3_JALR) begin
                    op.branch_op = ex_pkg::BR_JALR;
                    op.wr_en     = 1'b1;
                end
            end
            `EX_OPC_LUI: begin
                op.op_a   = '0;
                op.op_b   = imm_u;
                op.alu_op = ex_pkg::ALU_PASS_B;
                op.wr_en  = 1'b1;
            end
            `EX_OPC_AUIPC: begin
                op.op_a  = inst_addr_i;
                op.op_b  = imm_u;
                op.wr_en = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: ex_alu.sv
`include "ex_defs.svh"

module ex_alu (
    ex_op_if.alu          op,
    output ex_pkg::word_t alu_result_o
);

    localparam int SHW = $clog2(`EX_XLEN);

    logic [SHW-1:0] shamt;
    logic           lt_s;
    logic           lt_u;

    assign shamt = op.op_b[SHW-1:0];  // low five bits only
    assign lt_s  = $signed(op.op_a) < $signed(op.op_b);
    assign lt_u  = op.op_a < op.op_b;

    always_comb begin
        case (op.alu_op)
            ex_pkg::ALU_ADD:    alu_result_o = op.op_a + op.op_b;
            ex_pkg::ALU_SUB:    alu_result_o = op.op_a - op.op_b;
            ex_pkg::ALU_SLL:    alu_result_o = op.op_a << shamt;
            ex_pkg::ALU_SLT:    alu_result_o = ex_pkg::word_t'(lt_s);
            ex_pkg::ALU_SLTU:   alu_result_o = ex_pkg::word_t'(lt_u);
            ex_pkg::ALU_XOR:    alu_result_o = op.op_a ^ op.op_b;
            ex_pkg::ALU_SRL:    alu_result_o = op.op_a >> shamt;
            ex_pkg::ALU_SRA:    alu_result_o = ex_pkg::word_t'($signed(op.op_a) >>> shamt);
            ex_pkg::ALU_OR:     alu_result_o = op.op_a | op.op_b;
            ex_pkg::ALU_AND:    alu_result_o = op.op_a & op.op_b;
            ex_pkg::ALU_PASS_B: alu_result_o = op.op_b;
            default:            alu_result_o = '0;
        endcase
    end

endmodule

// File: ex_branch.sv
`include "ex_defs.svh"

module ex_branch (
    ex_op_if.branch       op,
    output logic          taken_o,
    output ex_pkg::word_t target_o
);

    logic          eq;
    logic          lt_s;
    logic          lt_u;
    ex_pkg::word_t pc_rel;
    ex_pkg::word_t reg_rel;

    assign eq   = op.op_a == op.op_b;
    assign lt_s = $signed(op.op_a) < $signed(op.op_b);
    assign lt_u = op.op_a < op.op_b;

    assign pc_rel  = op.pc + op.imm;    // branches and jal
    assign reg_rel = op.op_a + op.imm;  // jalr

    assign target_o = (op.branch_op == ex_pkg::BR_JALR) ?
                      {reg_rel[`EX_XLEN-1:1], 1'b0} : pc_rel;

    always_comb begin
        case (op.branch_op)
            ex_pkg::BR_BEQ:  taken_o = eq;
            ex_pkg::BR_BNE:  taken_o = !eq;
            ex_pkg::BR_BLT:  taken_o = lt_s;
            ex_pkg::BR_BGE:  taken_o = !lt_s;
            ex_pkg::BR_BLTU: taken_o = lt_u;
            ex_pkg::BR_BGEU: taken_o = !lt_u;
            ex_pkg::BR_JAL,
            ex_pkg::BR_JALR: taken_o = 1'b1;
            default:         taken_o = 1'b0;
        endcase
    end

endmodule

// File: ex_commit.sv
module ex_commit (
    input  logic              clk,
    input  logic              arst_n_i,
    ex_op_if.commit           op,
    input  ex_pkg::word_t     alu_result_i,
    input  logic              taken_i,
    input  ex_pkg::word_t     target_i,
    output logic              reg_we_o,
    output ex_pkg::reg_addr_t reg_waddr_o,
    output ex_pkg::word_t     reg_wdata_o,
    output logic              jump_flag_o,
    output ex_pkg::word_t     jump_addr_o
);

    logic          is_link;
    logic          do_write;
    logic          do_jump;
    ex_pkg::word_t wdata;

    assign is_link  = (op.branch_op == ex_pkg::BR_JAL) || (op.branch_op == ex_pkg::BR_JALR);
    assign wdata    = is_link ? op.pc + ex_pkg::word_t'(4) : alu_result_i;
    assign do_write = op.valid && op.wr_en;
    assign do_jump  = op.valid && taken_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            reg_wdata_o <= '0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            reg_we_o    <= do_write;  // one-cycle strobe
            jump_flag_o <= do_jump;
            if (do_write) begin
                reg_waddr_o <= op.rd;
                reg_wdata_o <= wdata;
            end
            if (do_jump) begin
                jump_addr_o <= target_i;
            end
        end
    end

endmodule

// File: ex_stage.sv
module ex_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  ex_pkg::word_t     inst_i,
    input  logic              inst_valid_i,
    input  ex_pkg::word_t     inst_addr_i,
    input  ex_pkg::word_t     reg1_rdata_i,
    input  ex_pkg::word_t     reg2_rdata_i,
    output logic              reg_we_o,
    output ex_pkg::reg_addr_t reg_waddr_o,
    output ex_pkg::word_t     reg_wdata_o,
    output logic              jump_flag_o,
    output ex_pkg::word_t     jump_addr_o
);

    ex_pkg::word_t alu_result;
    logic          taken;
    ex_pkg::word_t target;

    ex_op_if u_op_if ();

    ex_decode u_decode (
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .inst_addr_i  (inst_addr_i),
        .reg1_rdata_i (reg1_rdata_i),
        .reg2_rdata_i (reg2_rdata_i),
        .op           (u_op_if.producer)
    );

    ex_alu u_alu (
        .op           (u_op_if.alu),
        .alu_result_o (alu_result)
    );

    ex_branch u_branch (
        .op       (u_op_if.branch),
        .taken_o  (taken),
        .target_o (target)
    );

    // only registered stage gives the one-cycle latency
    ex_commit u_commit (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .op           (u_op_if.commit),
        .alu_result_i (alu_result),
        .taken_i      (taken),
        .target_i     (target),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .reg_wdata_o  (reg_wdata_o),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o)
    );

endmodule

// File: ex_properties.sv
module ex_properties (
    input logic          clk,
    input logic          arst_n_i,
    input logic          inst_valid_i,
    input logic          reg_we_o,
    input logic          jump_flag_o,
    input ex_pkg::word_t jump_addr_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    we_follows_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        reg_we_o |-> $past(inst_valid_i))
        else begin
            fail_cnt++;
            $error("reg_we_o high without a valid instruction one cycle earlier");
        end

    jump_follows_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        jump_flag_o |-> $past(inst_valid_i))
        else begin
            fail_cnt++;
            $error("jump_flag_o high without a valid instruction one cycle earlier");
        end

    jump_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        jump_flag_o |-> !jump_addr_o[0])
        else begin
            fail_cnt++;
            $error("jump_addr_o bit 0 set on a jump");
        end

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> (!reg_we_o && !jump_flag_o))
        else begin
            fail_cnt++;
            $error("strobe high while reset is asserted");
        end

endmodule

// File: tb_ex.sv
module tb_ex;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INST    = 300;
    localparam int MAX_CYCLE = 3000;  // five tests of 300 plus reset and drain

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        jf;
        logic [31:0] jaddr;
    } exp_t;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic [31:0] inst_i;
    logic        inst_valid_i;
    logic [31:0] inst_addr_i;
    logic [31:0] reg1_rdata_i;
    logic [31:0] reg2_rdata_i;
    logic        reg_we_o;
    logic [4:0]  reg_waddr_o;
    logic [31:0] reg_wdata_o;
    logic        jump_flag_o;
    logic [31:0] jump_addr_o;

    exp_t exp_q[$];
    exp_t held = '0;  // outputs hold their last strobed value
    int   n_check = 0;
    int   n_err = 0;
    int   cycle_cnt = 0;

    always #2 clk = ~clk;

    ex_stage uut (.*);

    bind ex_stage ex_properties u_props (.*);

    function automatic logic lt_signed(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, lt_signed(a, b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt && a[31]) begin
                    return (a >> b[4:0]) | ~(32'hffff_ffff >> b[4:0]);  // sign fill
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic exp_t ref_model(input logic [31:0] inst, input logic [31:0] pc,
                                       input logic [31:0] rs1, input logic [31:0] rs2);
        exp_t        e;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        e       = '0;
        f3      = inst[14:12];
        f7      = inst[31:25];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_u   = {inst[31:12], 12'b0};
        e.waddr = inst[11:7];
        case (inst[6:0])
            7'h13: begin
                e.we = (f3 == 3'd1) ? (f7 == 7'h00) :
                       (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
                e.wdata = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, rs1, imm_i);
            end
            7'h33: begin
                e.we    = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                e.wdata = alu_ref(f3, f7 == 7'h20, rs1, rs2);
            end
            7'h63: begin
                case (f3)
                    3'd0: e.jf = rs1 == rs2;
                    3'd1: e.jf = rs1 != rs2;
                    3'd4: e.jf = lt_signed(rs1, rs2);
                    3'd5: e.jf = !lt_signed(rs1, rs2);
                    3'd6: e.jf = rs1 < rs2;
                    3'd7: e.jf = rs1 >= rs2;
                    default: e.jf = 1'b0;
                endcase
                e.jaddr = pc + imm_b;
            end
            7'h6f: begin
                e.we    = 1'b1;
                e.wdata = pc + 32'd4;
                e.jf    = 1'b1;
                e.jaddr = pc + imm_j;
            end
            7'h67: begin
                e.we    = f3 == 3'd0;
                e.wdata = pc + 32'd4;
                e.jf    = f3 == 3'd0;
                e.jaddr = (rs1 + imm_i) & ~32'd1;
            end
            7'h37: begin
                e.we    = 1'b1;
                e.wdata = imm_u;
            end
            7'h17: begin
                e.we    = 1'b1;
                e.wdata = pc + imm_u;
            end
            default: begin
            end
        endcase
        return e;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        n_check++;
        assert (act_v === exp_v) else begin
            n_err++;
            $display("Error: time %0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    // compare last cycle's expectation, then queue the one for this edge
    always @(posedge clk) begin
        exp_t e;
        exp_t nxt;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_field("reg_we_o", 32'(e.we), 32'(reg_we_o));
            check_field("reg_waddr_o", 32'(e.waddr), 32'(reg_waddr_o));
            check_field("reg_wdata_o", e.wdata, reg_wdata_o);
            check_field("jump_flag_o", 32'(e.jf), 32'(jump_flag_o));
            check_field("jump_addr_o", e.jaddr, jump_addr_o);
        end
        nxt    = held;
        nxt.we = 1'b0;
        nxt.jf = 1'b0;
        if (arst_n_i && inst_valid_i) begin
            e      = ref_model(inst_i, inst_addr_i, reg1_rdata_i, reg2_rdata_i);
            nxt.we = e.we;
            nxt.jf = e.jf;
            if (e.we) begin
                nxt.waddr = e.waddr;
                nxt.wdata = e.wdata;
            end
            if (e.jf) begin
                nxt.jaddr = e.jaddr;
            end
        end
        if (!arst_n_i) begin
            nxt = '0;
        end
        held = nxt;
        exp_q.push_back(nxt);
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLE) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLE);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] pick_operand();
        case ($urandom() % 10)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'h7fff_ffff;
            3: return 32'h8000_0000;
            4: return 32'hffff_ffff;
            5: return 32'h8000_0001;
            default: return $urandom();
        endcase
    endfunction

    task automatic apply(input logic valid, input logic [31:0] inst,
                         input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        inst_valid_i = valid;
        inst_i       = inst;
        inst_addr_i  = $urandom() & 32'hffff_fffc;
        reg1_rdata_i = a;
        reg2_rdata_i = b;
    endtask

    task automatic gen_inst(input int id, input int i, output logic valid,
                            output logic [31:0] inst, output logic [31:0] a,
                            output logic [31:0] b);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        r     = $urandom();
        f3    = r[14:12];
        f7    = 7'h00;
        valid = 1'b1;
        a     = pick_operand();
        b     = pick_operand();
        case (id)
            1: begin
                if ((f3 == 3'd0 || f3 == 3'd5) && r[0]) begin
                    f7 = 7'h20;  // sub, sra
                end
                inst = {f7, r[24:15], f3, r[11:7], 7'h33};
            end
            2: begin
                f7 = r[31:25];
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    f7 = (f3 == 3'd5 && r[0]) ? 7'h20 : 7'h00;
                end
                inst = {f7, r[24:15], f3, r[11:7], 7'h13};
            end
            3: begin
                case (i % 6)
                    0: f3 = 3'd0;
                    1: f3 = 3'd1;
                    2: f3 = 3'd4;
                    3: f3 = 3'd5;
                    4: f3 = 3'd6;
                    default: f3 = 3'd7;
                endcase
                inst = {r[31:15], f3, r[11:7], 7'h63};
                case ((i / 6) % 3)
                    0: b = a;
                    1: begin  // sign bits differ
                        a = {r[1], a[30:0]};
                        b = {!r[1], b[30:0]};
                    end
                    default: begin
                        a = {r[1], a[30:0]};
                        b = {r[1], b[30:0]};
                    end
                endcase
            end
            default: begin
                case (i % 4)
                    0: opc = 7'h6f;
                    1: opc = 7'h67;
                    2: opc = 7'h37;
                    default: opc = 7'h17;
                endcase
                if (opc == 7'h67) begin
                    f3 = 3'b000;
                end
                inst = {r[31:15], f3, r[11:7], opc};
            end
        endcase
    endtask

    task automatic gen_mixed(input int i, output logic valid,
                             output logic [31:0] inst, output logic [31:0] a,
                             output logic [31:0] b);
        logic [31:0] r;
        logic [2:0]  f3;
        r     = $urandom();
        f3    = r[14:12];
        valid = 1'b1;
        a     = pick_operand();
        b     = pick_operand();
        case ($urandom() % 8)
            0, 1: begin
                valid = 1'b0;
                inst  = r;
            end
            2: begin  // load, store, fence, system
                case (r[1:0])
                    2'd0: inst = {r[31:7], 7'h03};
                    2'd1: inst = {r[31:7], 7'h23};
                    2'd2: inst = {r[31:7], 7'h0f};
                    default: inst = {r[31:7], 7'h73};
                endcase
            end
            3: begin
                case (r[1:0])
                    2'd0: inst = {7'h01, r[24:15], f3, r[11:7], 7'h33};  // m ext
                    2'd1: inst = {r[31:15], 2'b01, r[12], r[11:7], 7'h63};
                    2'd2: inst = {r[31:15], r[14:13], 1'b1, r[11:7], 7'h67};
                    default: inst = {7'h20, r[24:15], 3'd1, r[11:7], 7'h13};
                endcase
            end
            default: gen_inst(1 + $urandom() % 4, i, valid, inst, a, b);
        endcase
    endtask

    task automatic run_test(input int id, input string name);
        int          chk0;
        int          err0;
        logic        valid;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        chk0 = n_check;
        err0 = n_err;
        for (int i = 0; i < N_INST; i++) begin
            if (id == 5) begin
                gen_mixed(i, valid, inst, a, b);
            end else begin
                gen_inst(id, i, valid, inst, a, b);
            end
            apply(valid, inst, a, b);
        end
        apply(1'b0, 32'h0, 32'h0, 32'h0);
        @(negedge clk);  // last result compared by now
        $display("test %0d %s: %0d checks, %0d errors", id, name, n_check - chk0, n_err - err0);
    endtask

    initial begin
        void'($urandom(32'hddfd_051e));
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        reg1_rdata_i = '0;
        reg2_rdata_i = '0;
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;
        run_test(1, "reg-reg alu");
        run_test(2, "reg-imm alu");
        run_test(3, "branches");
        run_test(4, "jal jalr lui auipc");
        run_test(5, "mixed stream");
        $display("summary: %0d checks passed, %0d failed, %0d property failures",
                 n_check - n_err, n_err, uut.u_props.fail_cnt);
        if (n_err == 0 && uut.u_props.fail_cnt == 0 && n_check > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+.
ex_pkg.sv
ex_op_if.sv
ex_decode.sv
ex_alu.sv
ex_branch.sv
ex_commit.sv
ex_stage.sv
ex_properties.sv
tb_ex.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex -f all.f -o sim_ex
./obj_dir/sim_ex +verilator+error+limit+1000 | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
